/* compile.f */
src/cpu_pkg.sv
src/control_unit.sv
src/register_file.sv
src/alu.sv
src/hazard_forward.sv
src/datapath.sv
src/cpu_top.sv
dv/tb_cpu.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f --top-module tb_cpu \
   && out=$(./obj_dir/Vtb_cpu) \
   && echo "$out" \
   && echo "$out" | grep -q "^TEST OK$" \
   || { echo "simulation failed"; exit 1; }

/* dv/tb_cpu.sv */
module tb_cpu;
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] PC_INIT  = 32'h0000_0200;
   localparam int          PROG_LEN = 21;

   logic           CLK, reset, ihit, dhit, imemREN, dmemREN, dmemWEN, halt;
   cpu_pkg::word_t imemload, imemaddr, dmemload, dmemaddr, dmemstore;
   cpu_pkg::word_t rom [PROG_LEN];   // program image
   cpu_pkg::word_t ram [64];         // data memory, word addressed
   cpu_pkg::word_t exp_addr_q [$];   // store order from the ISA model
   cpu_pkg::word_t exp_dat_q [$];
   bit             rand_ihit, rand_dhit, halt_seen;
   int             store_idx, mem_errors, chk_errors, n_pass, n_fail;
   string          cur_test;

   cpu_top #(.PC_INIT(PC_INIT)) u_cpu_top (.*);

   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;   // 100 ns period
   end

   //////////////////////////////
   // encoders and fill pattern
   //////////////////////////////
   function automatic cpu_pkg::word_t encode_rtype(input logic [4:0] rs, input logic [4:0] rt,
         input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
      return {6'h00, rs, rt, rd, shamt, funct};
   endfunction

   function automatic cpu_pkg::word_t encode_itype(input logic [5:0] op, input logic [4:0] rs,
         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic cpu_pkg::word_t fill_word(input cpu_pkg::word_t addr);
      return (addr * 32'h0001_0001) ^ 32'h5a5a_c3c3;   // every address bit shows up
   endfunction

   task automatic load_program();
      // dependent alu chain where each result feeds the next instruction
      rom[0]  = encode_itype(cpu_pkg::LUI,   5'd0, 5'd1, 16'h1234);
      rom[1]  = encode_itype(cpu_pkg::ORI,   5'd1, 5'd1, 16'h5678);    // mem forward
      rom[2]  = encode_itype(cpu_pkg::ADDIU, 5'd0, 5'd2, 16'hfffd);    // sign extended
      rom[3]  = encode_rtype(5'd1, 5'd2, 5'd3, 5'd0, cpu_pkg::SUBU);   // wb + mem forward
      rom[4]  = encode_rtype(5'd2, 5'd1, 5'd4, 5'd0, cpu_pkg::SLT);    // signed compare gives 1
      rom[5]  = encode_rtype(5'd0, 5'd3, 5'd5, 5'd4, cpu_pkg::SLL);
      rom[6]  = encode_rtype(5'd5, 5'd1, 5'd6, 5'd0, cpu_pkg::AND);
      rom[7]  = encode_rtype(5'd6, 5'd4, 5'd7, 5'd0, cpu_pkg::OR);
      rom[8]  = encode_itype(cpu_pkg::SW,    5'd0, 5'd5, 16'h0008);
      rom[9]  = encode_itype(cpu_pkg::SW,    5'd0, 5'd7, 16'h0004);    // rt from wb under a data wait
      rom[10] = encode_rtype(5'd3, 5'd5, 5'd8, 5'd0, cpu_pkg::ADDU);
      rom[11] = encode_itype(cpu_pkg::SW,    5'd0, 5'd8, 16'h000c);
      // load-use pairs
      rom[12] = encode_itype(cpu_pkg::LW,    5'd0, 5'd9, 16'h0010);
      rom[13] = encode_rtype(5'd9, 5'd1, 5'd10, 5'd0, cpu_pkg::ADDU);
      rom[14] = encode_itype(cpu_pkg::SW,    5'd0, 5'd10, 16'h0014);
      rom[15] = encode_itype(cpu_pkg::LW,    5'd0, 5'd11, 16'h0004);   // reads back rom[9] store
      rom[16] = encode_rtype(5'd11, 5'd9, 5'd12, 5'd0, cpu_pkg::SUBU);
      rom[17] = encode_itype(cpu_pkg::SW,    5'd0, 5'd12, 16'h0018);
      rom[18] = encode_itype(cpu_pkg::ORI,   5'd0, 5'd13, 16'h8001);   // zero extended
      rom[19] = encode_itype(cpu_pkg::SW,    5'd0, 5'd13, 16'h001c);
      rom[20] = {cpu_pkg::HALT, 26'h0};
   endtask

   //////////////////////////////
   // sequential ISA model
   //////////////////////////////
   task automatic build_expected();
      cpu_pkg::word_t    r [32];
      cpu_pkg::word_t    m [64];
      cpu_pkg::word_t    w, a, sx;
      cpu_pkg::regbits_t rs, rt, rd;
      int                pc;
      bit                done;
      for (int i = 0; i < 32; i++) r[i] = '0;
      for (int i = 0; i < 64; i++) m[i] = fill_word(i * 4);
      pc   = 0;
      done = 1'b0;
      while (!done && pc < PROG_LEN) begin
         w  = rom[pc];
         rs = w[25:21];
         rt = w[20:16];
         rd = w[15:11];
         sx = {{16{w[15]}}, w[15:0]};
         a  = r[rs] + sx;   // load/store address
         case (w[31:26])
            cpu_pkg::RTYPE: begin
               case (w[5:0])
                  cpu_pkg::ADDU: r[rd] = r[rs] + r[rt];
                  cpu_pkg::SUBU: r[rd] = r[rs] - r[rt];
                  cpu_pkg::AND:  r[rd] = r[rs] & r[rt];
                  cpu_pkg::OR:   r[rd] = r[rs] | r[rt];
                  cpu_pkg::SLT:  r[rd] = {31'b0, $signed(r[rs]) < $signed(r[rt])};
                  cpu_pkg::SLL:  r[rd] = r[rt] << w[10:6];
                  default: ;
               endcase
            end
            cpu_pkg::ADDIU: r[rt] = a;
            cpu_pkg::ORI:   r[rt] = r[rs] | {16'h0, w[15:0]};
            cpu_pkg::LUI:   r[rt] = {w[15:0], 16'h0};
            cpu_pkg::LW:    r[rt] = m[a[7:2]];
            cpu_pkg::SW: begin
               m[a[7:2]] = r[rt];
               exp_addr_q.push_back(a);
               exp_dat_q.push_back(r[rt]);
            end
            cpu_pkg::HALT:  done = 1'b1;
            default: ;
         endcase
         r[0] = '0;
         pc++;
      end
   endtask

   //////////////////////////////
   // memory models + store checks
   //////////////////////////////
   initial begin : memory_model
      int          wait_left;
      int          iidx;
      logic        rst_edge;
      logic [31:0] off;
      ihit       = 1'b0;
      dhit       = 1'b0;
      imemload   = '0;
      dmemload   = '0;
      store_idx  = 0;
      mem_errors = 0;
      halt_seen  = 1'b0;
      wait_left  = -1;
      void'($urandom(32'hebc344e9));
      forever begin
         @(posedge CLK);
         rst_edge = reset;   // value the DUT just registered
         #5;
         if (rst_edge) begin
            for (int i = 0; i < 64; i++) ram[i] = fill_word(i * 4);
            store_idx = 0;
            halt_seen = 1'b0;
            wait_left = -1;
            ihit      = 1'b0;
            dhit      = 1'b0;
         end else begin
            // fetch answers in the same cycle with random gaps
            off      = imemaddr - PC_INIT;
            iidx     = int'(off >> 2);
            ihit     = imemREN && (!rand_ihit || $urandom % 3 != 0);
            imemload = (off < PROG_LEN * 4) ? rom[iidx] : '0;
            if (dmemREN || dmemWEN) begin
               if (wait_left < 0) wait_left = rand_dhit ? int'($urandom % 4) : 0;
               if (wait_left == 0) begin
                  dhit      = 1'b1;
                  wait_left = -1;
                  dmemload  = ram[dmemaddr[7:2]];
                  if (dmemWEN) begin
                     assert (store_idx < exp_addr_q.size()) else begin
                        $display("%s: extra store to %h", cur_test, dmemaddr);
                        mem_errors++;
                     end
                     assert (store_idx >= exp_addr_q.size() ||
                             (dmemaddr == exp_addr_q[store_idx] &&
                              dmemstore == exp_dat_q[store_idx])) else begin
                        $display("Error %s: store %0d expected %h=%h actual %h=%h", cur_test,
                                 store_idx, exp_addr_q[store_idx], exp_dat_q[store_idx],
                                 dmemaddr, dmemstore);
                        mem_errors++;
                     end
                     ram[dmemaddr[7:2]] = dmemstore;
                     store_idx++;
                  end
               end else begin
                  dhit = 1'b0;   // still waiting
                  wait_left--;
               end
            end else begin
               dhit      = 1'b0;
               wait_left = -1;
            end
            // halt is sticky and nothing is stored once it is up
            if (halt_seen) begin
               assert (halt) else begin
                  $display("%s: halt dropped without a reset", cur_test);
                  mem_errors++;
               end
            end else if (halt) begin
               halt_seen = 1'b1;
               assert (store_idx == exp_addr_q.size()) else begin
                  $display("Error %s: stores at halt expected %0d actual %0d", cur_test,
                           exp_addr_q.size(), store_idx);
                  mem_errors++;
               end
            end
            assert (!(halt && dmemWEN)) else begin
               $display("%s: store issued while halted", cur_test);
               mem_errors++;
            end
         end
      end
   end

   //////////////////////////////
   // test sequence
   //////////////////////////////
   task automatic check_equal(input string what, input cpu_pkg::word_t expected,
         input cpu_pkg::word_t actual);
      assert (actual == expected) else begin
         $display("Error %s: %s expected %h actual %h", cur_test, what, expected, actual);
         chk_errors++;
      end
   endtask

   task automatic apply_reset(input bit rnd_i, input bit rnd_d);
      reset = 1'b1;
      @(posedge CLK);
      rand_ihit = rnd_i;   // memory model reads these out of reset only
      rand_dhit = rnd_d;
      repeat (9) @(posedge CLK);
      #5;
      check_equal("halt", 32'd0, {31'b0, halt});
      check_equal("dmemREN", 32'd0, {31'b0, dmemREN});
      check_equal("dmemWEN", 32'd0, {31'b0, dmemWEN});
      check_equal("imemREN", 32'd1, {31'b0, imemREN});
      check_equal("imemaddr", PC_INIT, imemaddr);
      reset = 1'b0;
   endtask

   task automatic wait_for_halt(input int limit);
      int n;
      n = 0;
      while (!halt && n < limit) begin
         @(posedge CLK);
         #5;
         n++;
      end
      if (!halt) begin
         $display("%s: no halt within %0d cycles", cur_test, limit);
         chk_errors++;
      end
   endtask

   task automatic report_test(input string name, input int base);
      if (mem_errors + chk_errors == base) begin
         n_pass++;
         $display("%s: pass", name);
      end else begin
         n_fail++;
         $display("%s: fail with %0d errors", name, mem_errors + chk_errors - base);
      end
   endtask

   task automatic run_program(input string name, input bit rnd_i, input bit rnd_d,
         input bit halted_before);
      int base;
      base     = mem_errors + chk_errors;
      cur_test = name;
      if (halted_before) check_equal("halt before reset", 32'd1, {31'b0, halt});
      apply_reset(rnd_i, rnd_d);
      wait_for_halt(2000);
      repeat (20) @(posedge CLK);   // halt must hold and the data port stay idle
      #5;
      check_equal("store count", exp_addr_q.size(), store_idx);
      report_test(name, base);
   endtask

   initial begin : stimulus
      reset      = 1'b1;
      rand_ihit  = 1'b0;
      rand_dhit  = 1'b0;
      chk_errors = 0;
      n_pass     = 0;
      n_fail     = 0;
      cur_test   = "reset_state";
      load_program();
      build_expected();
      apply_reset(1'b0, 1'b0);
      report_test("reset_state", 0);
      run_program("alu_forward_load_use", 1'b0, 1'b0, 1'b0);
      run_program("data_backpressure", 1'b0, 1'b1, 1'b0);
      run_program("fetch_stalls", 1'b1, 1'b0, 1'b0);
      run_program("halt_rerun", 1'b1, 1'b1, 1'b1);   // rerun straight out of halt
      $display("tests %0d passed %0d failed, %0d errors", n_pass, n_fail,
               mem_errors + chk_errors);
      if (n_fail == 0 && mem_errors + chk_errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* src/cpu_top.sv */
module cpu_top #(
   parameter logic [31:0] PC_INIT = 32'h0
) (
   input  logic           CLK,
   input  logic           reset,
   input  logic           ihit,
   input  cpu_pkg::word_t imemload,
   output logic           imemREN,
   output cpu_pkg::word_t imemaddr,
   input  logic           dhit,
   input  cpu_pkg::word_t dmemload,
   output logic           dmemREN,
   output logic           dmemWEN,
   output cpu_pkg::word_t dmemaddr,
   output cpu_pkg::word_t dmemstore,
   output logic           halt
);

   datapath #(.PC_INIT(PC_INIT)) u_datapath (
      .CLK(CLK), .reset(reset),
      .ihit(ihit), .imemload(imemload), .imemREN(imemREN), .imemaddr(imemaddr),
      .dhit(dhit), .dmemload(dmemload), .dmemREN(dmemREN), .dmemWEN(dmemWEN),
      .dmemaddr(dmemaddr), .dmemstore(dmemstore), .halt(halt)
   );

endmodule

/* src/datapath.sv */
module datapath #(
   parameter logic [31:0] PC_INIT = 32'h0
) (
   input  logic           CLK,
   input  logic           reset,
   // instruction port
   input  logic           ihit,
   input  cpu_pkg::word_t imemload,
   output logic           imemREN,
   output cpu_pkg::word_t imemaddr,
   // data port
   input  logic           dhit,
   input  cpu_pkg::word_t dmemload,
   output logic           dmemREN,
   output logic           dmemWEN,
   output cpu_pkg::word_t dmemaddr,
   output cpu_pkg::word_t dmemstore,
   output logic           halt
);

   cpu_pkg::word_t    pc;
   cpu_pkg::fd_t      fd, fd_in;
   cpu_pkg::de_t      de, de_in;
   cpu_pkg::em_t      em, em_in;
   cpu_pkg::mw_t      mw, mw_in;
   cpu_pkg::ctrl_t    ctrl;
   logic              extop;
   cpu_pkg::word_t    rdat1, rdat2, wdat;
   cpu_pkg::word_t    op1_fwd, op2_fwd, op2, alu_res;
   cpu_pkg::regbits_t wsel_ex;
   logic              pc_en, fd_en, de_en, de_flush, em_en, mw_bubble;
   cpu_pkg::fwd_t     fwd_op1, fwd_op2;
   logic              halt_q;

   control_unit u_control_unit (.instr(fd.instr), .ctrl(ctrl), .extop(extop));

   register_file u_register_file (
      .CLK(CLK), .reset(reset),
      .rsel1(fd.instr[25:21]), .rsel2(fd.instr[20:16]),
      .wsel(mw.wsel), .wen(mw.valid && mw.regwr), .wdat(wdat),
      .rdat1(rdat1), .rdat2(rdat2)
   );

   alu u_alu (
      .op1(op1_fwd), .op2(op2), .shamt(de.shamt), .alu_op(de.ctrl.alu_op), .res(alu_res)
   );

   hazard_forward u_hazard_forward (
      .de(de), .em(em), .mw(mw),
      .id_rs(fd.instr[25:21]), .id_rt(fd.instr[20:16]), .id_halt(ctrl.halt),
      .ihit(ihit), .dhit(dhit),
      .pc_en(pc_en), .fd_en(fd_en), .de_en(de_en), .de_flush(de_flush),
      .em_en(em_en), .mw_bubble(mw_bubble),
      .fwd_op1(fwd_op1), .fwd_op2(fwd_op2)
   );

   //////////////////////////////
   // fetch
   //////////////////////////////
   assign imemaddr        = pc;
   assign imemREN         = !halt;
   assign fd_in.instr     = ihit ? imemload : '0;   // missed fetch becomes a bubble
   assign fd_in.pc_plus_4 = ihit ? pc + 32'd4 : '0;

   //////////////////////////////
   // decode + extender
   //////////////////////////////
   always_comb begin
      de_in.ctrl  = ctrl;
      de_in.rdat1 = rdat1;
      de_in.rdat2 = rdat2;
      de_in.imm32 = extop ? {{16{fd.instr[15]}}, fd.instr[15:0]} : {16'b0, fd.instr[15:0]};
      de_in.rs    = fd.instr[25:21];
      de_in.rt    = fd.instr[20:16];
      de_in.rd    = fd.instr[15:11];
      de_in.shamt = fd.instr[10:6];
      de_in.valid = fd.pc_plus_4 != '0;
   end

   //////////////////////////////
   // execute
   //////////////////////////////
   always_comb begin
      case (fwd_op1)
         cpu_pkg::FWD_MEM: op1_fwd = em.alu_res;
         cpu_pkg::FWD_WB:  op1_fwd = wdat;
         default:          op1_fwd = de.rdat1;
      endcase
      case (fwd_op2)
         cpu_pkg::FWD_MEM: op2_fwd = em.alu_res;
         cpu_pkg::FWD_WB:  op2_fwd = wdat;
         default:          op2_fwd = de.rdat2;
      endcase
      case (de.ctrl.alu_src)
         cpu_pkg::SRC_IMM: op2 = de.imm32;
         cpu_pkg::SRC_LUI: op2 = {de.imm32[15:0], 16'b0};
         default:          op2 = op2_fwd;
      endcase
   end

   assign wsel_ex = de.ctrl.regdst_rt ? de.rt : de.rd;   // regdst

   always_comb begin
      em_in.ctrl      = de.ctrl;
      em_in.alu_res   = alu_res;
      em_in.store_dat = op2_fwd;   // sw data is the forwarded rt
      em_in.wsel      = wsel_ex;
      em_in.valid     = de.valid;
   end

   //////////////////////////////
   // memory + writeback
   //////////////////////////////
   assign dmemREN   = em.valid && em.ctrl.dmemren;   // held until dhit
   assign dmemWEN   = em.valid && em.ctrl.dmemwen;
   assign dmemaddr  = em.alu_res;
   assign dmemstore = em.store_dat;

   always_comb begin
      mw_in.regwr    = em.ctrl.regwr;
      mw_in.memtoreg = em.ctrl.memtoreg;
      mw_in.halt     = em.ctrl.halt;
      mw_in.alu_res  = em.alu_res;
      mw_in.dmemload = dmemload;
      mw_in.wsel     = em.wsel;
      mw_in.valid    = em.valid;
   end

   assign wdat = mw.memtoreg ? mw.dmemload : mw.alu_res;   // memtoreg
   assign halt = halt_q || (mw.valid && mw.halt);

   //////////////////////////////
   // pc + latches
   //////////////////////////////
   always_ff @(posedge CLK) begin
      if (reset) begin
         pc     <= PC_INIT;
         halt_q <= 1'b0;
         fd     <= '0;
         de     <= '0;
         em     <= '0;
         mw     <= '0;
      end else begin
         if (pc_en) pc <= fd_in.pc_plus_4;   // shares the fetch adder
         if (mw.valid && mw.halt) halt_q <= 1'b1;   // sticky until reset
         if (fd_en) fd <= fd_in;
         if (de_flush) begin
            de <= '0;
         end else if (de_en) begin
            de <= de_in;
         end else begin
            // held on memory wait, keep operands current as older writes retire
            de.rdat1 <= op1_fwd;
            de.rdat2 <= op2_fwd;
         end
         if (em_en) em <= em_in;
         mw <= mw_bubble ? '0 : mw_in;
      end
   end

endmodule

/* src/hazard_forward.sv */
module hazard_forward (
   input  cpu_pkg::de_t      de,
   input  cpu_pkg::em_t      em,
   input  cpu_pkg::mw_t      mw,
   input  cpu_pkg::regbits_t id_rs,
   input  cpu_pkg::regbits_t id_rt,
   input  logic              id_halt,
   input  logic              ihit,
   input  logic              dhit,
   output logic              pc_en,
   output logic              fd_en,
   output logic              de_en,
   output logic              de_flush,
   output logic              em_en,
   output logic              mw_bubble,
   output cpu_pkg::fwd_t     fwd_op1,
   output cpu_pkg::fwd_t     fwd_op2
);

   logic load_use, mem_wait, mem_fwd_ok, wb_fwd_ok;

   //////////////////////////////
   // stalls
   //////////////////////////////
   assign load_use = de.valid && de.ctrl.dmemren && de.rt != '0 &&
                     (de.rt == id_rs || de.rt == id_rt);   // may over-stall on i-type rt
   assign mem_wait = em.valid && (em.ctrl.dmemren || em.ctrl.dmemwen) && !dhit;

   assign pc_en     = ihit && !load_use && !mem_wait && !id_halt;
   assign fd_en     = !load_use && !mem_wait && !id_halt;   // halt parks in decode
   assign de_en     = !mem_wait;
   assign de_flush  = load_use && !mem_wait;   // bubble behind the load
   assign em_en     = !mem_wait;
   assign mw_bubble = mem_wait;   // older writeback done once

   //////////////////////////////
   // forwarding
   //////////////////////////////
   assign mem_fwd_ok = em.valid && em.ctrl.regwr && em.wsel != '0;
   assign wb_fwd_ok  = mw.valid && mw.regwr && mw.wsel != '0;

   always_comb begin
      fwd_op1 = cpu_pkg::FWD_NONE;
      fwd_op2 = cpu_pkg::FWD_NONE;
      if (mem_fwd_ok && em.wsel == de.rs)     fwd_op1 = cpu_pkg::FWD_MEM;   // youngest wins
      else if (wb_fwd_ok && mw.wsel == de.rs) fwd_op1 = cpu_pkg::FWD_WB;
      if (mem_fwd_ok && em.wsel == de.rt)     fwd_op2 = cpu_pkg::FWD_MEM;
      else if (wb_fwd_ok && mw.wsel == de.rt) fwd_op2 = cpu_pkg::FWD_WB;
   end

endmodule

/* src/alu.sv */
module alu (
   input  cpu_pkg::word_t  op1,
   input  cpu_pkg::word_t  op2,
   input  logic [4:0]      shamt,
   input  cpu_pkg::aluop_t alu_op,
   output cpu_pkg::word_t  res
);

   always_comb begin
      case (alu_op)
         cpu_pkg::ALU_ADD: res = op1 + op2;
         cpu_pkg::ALU_SUB: res = op1 - op2;
         cpu_pkg::ALU_AND: res = op1 & op2;
         cpu_pkg::ALU_OR:  res = op1 | op2;
         cpu_pkg::ALU_SLT: begin
            // signed compare, result in bit 0
            res = {31'b0, $signed(op1) < $signed(op2)};
         end
         cpu_pkg::ALU_SLL: res = op2 << shamt;   // shifts rt, not rs
         default:          res = '0;
      endcase
   end

endmodule

/* src/register_file.sv */
module register_file (
   input  logic              CLK,
   input  logic              reset,
   input  cpu_pkg::regbits_t rsel1,
   input  cpu_pkg::regbits_t rsel2,
   input  cpu_pkg::regbits_t wsel,
   input  logic              wen,
   input  cpu_pkg::word_t    wdat,
   output cpu_pkg::word_t    rdat1,
   output cpu_pkg::word_t    rdat2
);

   cpu_pkg::word_t regs [32];

   always_ff @(posedge CLK) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) regs[i] <= '0;
      end else if (wen && wsel != '0) begin
         regs[wsel] <= wdat;   // r0 never written
      end
   end

   // write-through so decode sees the writeback value this cycle
   always_comb begin
      rdat1 = (wen && wsel == rsel1) ? wdat : regs[rsel1];
      rdat2 = (wen && wsel == rsel2) ? wdat : regs[rsel2];
      if (rsel1 == '0) rdat1 = '0;
      if (rsel2 == '0) rdat2 = '0;
   end

endmodule

/* src/control_unit.sv */
module control_unit (
   input  cpu_pkg::word_t instr,
   output cpu_pkg::ctrl_t ctrl,
   output logic           extop    // 1 = sign extend imm16
);

   cpu_pkg::opcode_t op;
   cpu_pkg::funct_t  fn;

   assign op = cpu_pkg::opcode_t'(instr[31:26]);
   assign fn = cpu_pkg::funct_t'(instr[5:0]);

   always_comb begin
      ctrl  = '0;   // bubble unless recognized
      extop = 1'b0;
      case (op)
         cpu_pkg::RTYPE: begin
            ctrl.regwr = 1'b1;     // dest is rd
            case (fn)
               cpu_pkg::ADDU: ctrl.alu_op = cpu_pkg::ALU_ADD;
               cpu_pkg::SUBU: ctrl.alu_op = cpu_pkg::ALU_SUB;
               cpu_pkg::AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
               cpu_pkg::OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
               cpu_pkg::SLT:  ctrl.alu_op = cpu_pkg::ALU_SLT;
               cpu_pkg::SLL:  ctrl.alu_op = cpu_pkg::ALU_SLL;
               default:       ctrl.regwr  = 1'b0;  // unknown funct
            endcase
         end
         cpu_pkg::ADDIU: begin
            ctrl.alu_src   = cpu_pkg::SRC_IMM;
            ctrl.regwr     = 1'b1;
            ctrl.regdst_rt = 1'b1;
            extop          = 1'b1;
         end
         cpu_pkg::ORI: begin
            ctrl.alu_op    = cpu_pkg::ALU_OR;
            ctrl.alu_src   = cpu_pkg::SRC_IMM;   // zero extended
            ctrl.regwr     = 1'b1;
            ctrl.regdst_rt = 1'b1;
         end
         cpu_pkg::LUI: begin
            ctrl.alu_src   = cpu_pkg::SRC_LUI;   // rs is r0, so add passes op2
            ctrl.regwr     = 1'b1;
            ctrl.regdst_rt = 1'b1;
         end
         cpu_pkg::LW: begin
            ctrl.alu_src   = cpu_pkg::SRC_IMM;
            ctrl.regwr     = 1'b1;
            ctrl.memtoreg  = 1'b1;
            ctrl.dmemren   = 1'b1;
            ctrl.regdst_rt = 1'b1;
            extop          = 1'b1;
         end
         cpu_pkg::SW: begin
            ctrl.alu_src = cpu_pkg::SRC_IMM;
            ctrl.dmemwen = 1'b1;
            extop        = 1'b1;
         end
         cpu_pkg::HALT: ctrl.halt = 1'b1;
         default: ;   // unknown opcode stays a bubble
      endcase
   end

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

   //////////////////////////////
   // base types
   //////////////////////////////
   typedef logic [31:0] word_t;
   typedef logic [4:0]  regbits_t;

   // instr[31:26]
   typedef enum logic [5:0] {
      RTYPE = 6'h00,
      ADDIU = 6'h09,
      ORI   = 6'h0d,
      LUI   = 6'h0f,
      LW    = 6'h23,
      SW    = 6'h2b,
      HALT  = 6'h3f
   } opcode_t;

   // instr[5:0] for RTYPE
   typedef enum logic [5:0] {
      SLL  = 6'h00,
      ADDU = 6'h21,
      SUBU = 6'h23,
      AND  = 6'h24,
      OR   = 6'h25,
      SLT  = 6'h2a
   } funct_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL
   } aluop_t;

   typedef enum logic [1:0] {
      SRC_REG,   // forwarded rt
      SRC_IMM,   // extended imm16
      SRC_LUI    // imm16 in upper half
   } alusrc_t;

   typedef enum logic [1:0] {
      FWD_NONE, FWD_MEM, FWD_WB
   } fwd_t;

   //////////////////////////////
   // control + pipeline latches
   //////////////////////////////
   typedef struct packed {
      aluop_t   alu_op;
      alusrc_t  alu_src;
      logic     regwr;
      logic     memtoreg;    // writeback from dmemload
      logic     dmemren;
      logic     dmemwen;
      logic     regdst_rt;   // i-type dest is rt
      logic     halt;
   } ctrl_t;

   typedef struct packed {
      word_t    instr;
      word_t    pc_plus_4;   // zero marks a bubble
   } fd_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    rdat1;
      word_t    rdat2;
      word_t    imm32;
      regbits_t rs;
      regbits_t rt;
      regbits_t rd;
      logic [4:0] shamt;
      logic     valid;
   } de_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    alu_res;     // also the data address
      word_t    store_dat;
      regbits_t wsel;
      logic     valid;
   } em_t;

   typedef struct packed {
      logic     regwr;
      logic     memtoreg;
      logic     halt;
      word_t    alu_res;
      word_t    dmemload;
      regbits_t wsel;
      logic     valid;
   } mw_t;

endpackage
